// ==== design/uart_pkg.sv ====
// UART transmitter types and line constants, imported by the serial transmit modules
package uart_pkg;

    // ========================================
    // Character and line definitions
    // ========================================
    localparam int   UART_DATA_BITS  = 8;     // 8N1 framing
    localparam logic UART_IDLE_LEVEL = 1'b1;  // Idle and stop bit level

    typedef logic [UART_DATA_BITS-1:0] uart_byte_t;  // One character on the wire

    // ========================================
    // Transmit FSM states
    // ========================================
    typedef enum logic [1:0] {
        UART_IDLE  = 2'd0,  // Line held high, waiting for send
        UART_START = 2'd1,  // Start bit, line low
        UART_DATA  = 2'd2,  // Data bits, LSB first
        UART_STOP  = 2'd3   // Stop bit, line high
    } uart_state_e;

endpackage

// ==== design/dbg_msg_pkg.sv ====
// Debug line layout, field positions and ASCII constants shared by the message modules
package dbg_msg_pkg;

    // ========================================
    // Counter widths
    // ========================================
    localparam int CNT_W = 16;  // Frame, instruction, IOT and pulse counters
    localparam int PC_W  = 12;  // CPU program counter

    // ========================================
    // Line layout
    // ========================================
    // F:hhhh PC:hhh I:hhhh D:hhhh V:dddd R<CR><LF>
    localparam int MSG_LEN = 38;

    typedef logic [5:0] msg_idx_t;  // Character index within the line

    // First digit of each field, label and colon sit just before it
    localparam msg_idx_t POS_FRAME = 6'd2;
    localparam msg_idx_t POS_PC    = 6'd10;
    localparam msg_idx_t POS_INSTR = 6'd16;
    localparam msg_idx_t POS_IOT   = 6'd23;
    localparam msg_idx_t POS_PV    = 6'd30;
    localparam msg_idx_t POS_RUN   = 6'd35;  // Followed by CR and LF

    // ASCII codes
    localparam logic [7:0] ASCII_0     = 8'h30;
    localparam logic [7:0] ASCII_A     = 8'h41;
    localparam logic [7:0] ASCII_SPACE = 8'h20;
    localparam logic [7:0] ASCII_COLON = 8'h3A;
    localparam logic [7:0] ASCII_R     = 8'h52;
    localparam logic [7:0] ASCII_DOT   = 8'h2E;  // CPU halted
    localparam logic [7:0] ASCII_CR    = 8'h0D;
    localparam logic [7:0] ASCII_LF    = 8'h0A;

    // ========================================
    // Message FSM states
    // ========================================
    typedef enum logic [1:0] {
        MSG_IDLE = 2'd0,  // Waiting for a snapshot
        MSG_SEND = 2'd1,  // Handing a character to the transmitter
        MSG_WAIT = 2'd2   // Waiting for the transmitter to take it
    } msg_state_e;

endpackage

// ==== design/baud_timer.sv ====
// Bit period timer for the UART transmitter, flags the last clock of every bit
module baud_timer #(
    parameter int CLKS_PER_BIT = 443
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_run,      // High while a character is on the line
    output logic o_bit_done  // Last cycle of the current bit
);

    localparam int TMR_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [TMR_W-1:0] LAST_CNT = TMR_W'(CLKS_PER_BIT - 1);

    logic [TMR_W-1:0] cnt_q;  // Clocks into the current bit

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (!i_run) begin
            cnt_q <= '0;  // Next character starts aligned
        end else if (cnt_q == LAST_CNT) begin
            cnt_q <= '0;  // Wrap into next bit
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Qualified by run so an idle count of zero never fires
    assign o_bit_done = i_run && (cnt_q == LAST_CNT);

endmodule

// ==== design/uart_tx.sv ====
// 8N1 UART transmitter, takes one character per send pulse and reports busy until the stop bit ends
module uart_tx #(
    parameter int CLKS_PER_BIT = 443
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  uart_pkg::uart_byte_t i_data,  // Sampled with i_send
    input  logic                 i_send,  // One cycle, ignored unless idle
    output logic                 o_tx,    // Registered serial line
    output logic                 o_busy
);

    import uart_pkg::*;

    localparam int BIT_CNT_W = $clog2(UART_DATA_BITS);
    localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(UART_DATA_BITS - 1);

    uart_state_e          state_q;
    uart_byte_t           shift_q;    // Remaining data bits, next one in bit 0
    logic [BIT_CNT_W-1:0] bit_cnt_q;  // Data bit now on the line
    logic                 timer_run;
    logic                 bit_done;

    assign timer_run = (state_q != UART_IDLE);  // Timer cleared between characters

    baud_timer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) baud_timer_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_run      (timer_run),
        .o_bit_done (bit_done)
    );

    // ========================================
    // Bit sequencing
    // ========================================
    // Line level is set on the edge that enters each bit
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q   <= UART_IDLE;
            bit_cnt_q <= '0;
            o_tx      <= UART_IDLE_LEVEL;
            o_busy    <= 1'b0;
        end else begin
            case (state_q)
                UART_IDLE: begin
                    if (i_send) begin
                        state_q <= UART_START;
                        o_tx    <= ~UART_IDLE_LEVEL;  // Start bit
                        o_busy  <= 1'b1;
                    end
                end
                UART_START: begin
                    if (bit_done) begin
                        state_q   <= UART_DATA;
                        bit_cnt_q <= '0;
                        o_tx      <= shift_q[0];  // LSB first
                    end
                end
                UART_DATA: begin
                    if (bit_done) begin
                        if (bit_cnt_q == LAST_BIT) begin
                            state_q <= UART_STOP;
                            o_tx    <= UART_IDLE_LEVEL;  // Stop bit
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            o_tx      <= shift_q[1];  // Bit after the one just sent
                        end
                    end
                end
                UART_STOP: begin
                    if (bit_done) begin
                        state_q <= UART_IDLE;
                        o_busy  <= 1'b0;  // Free for the next character
                    end
                end
                default: state_q <= UART_IDLE;
            endcase
        end
    end

    // Character shift register
    always_ff @(posedge i_clk) begin
        if (state_q == UART_IDLE && i_send) begin
            shift_q <= i_data;
        end else if (state_q == UART_DATA && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// ==== design/frame_stats.sv ====
// Per-frame statistics, counts frames and pixel pulses and captures the snapshot sent each frame
module frame_stats (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_frame_tick,   // One cycle per frame
    input  logic                          i_pixel_avail,  // Pixel pipeline pulse
    input  logic [dbg_msg_pkg::PC_W-1:0]  i_cpu_pc,
    input  logic [dbg_msg_pkg::CNT_W-1:0] i_cpu_instr_count,
    input  logic [dbg_msg_pkg::CNT_W-1:0] i_cpu_iot_count,
    input  logic                          i_cpu_running,
    input  logic                          i_msg_active,   // Line still going out
    output logic                          o_snap_valid,
    output logic [dbg_msg_pkg::CNT_W-1:0] o_frame,
    output logic [dbg_msg_pkg::PC_W-1:0]  o_pc,
    output logic [dbg_msg_pkg::CNT_W-1:0] o_instr,
    output logic [dbg_msg_pkg::CNT_W-1:0] o_iot,
    output logic [dbg_msg_pkg::CNT_W-1:0] o_pv_count,
    output logic                          o_running
);

    import dbg_msg_pkg::*;

    logic [CNT_W-1:0] frame_cnt_q;  // Frames seen since reset
    logic [CNT_W-1:0] pv_cnt_q;     // Pulses in the current frame
    logic             capture;

    // Ticks during a message still count but are not reported
    assign capture = i_frame_tick && !i_msg_active;

    // ========================================
    // Counters
    // ========================================
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            frame_cnt_q  <= '0;
            pv_cnt_q     <= '0;
            o_snap_valid <= 1'b0;
        end else begin
            if (i_frame_tick) begin
                frame_cnt_q <= frame_cnt_q + 1'b1;
                // A pulse on the tick cycle belongs to the new frame
                pv_cnt_q    <= {{(CNT_W-1){1'b0}}, i_pixel_avail};
            end else if (i_pixel_avail) begin
                pv_cnt_q <= pv_cnt_q + 1'b1;
            end
            o_snap_valid <= capture;  // Snapshot visible in the same cycle
        end
    end

    // ========================================
    // Snapshot
    // ========================================
    always_ff @(posedge i_clk) begin
        if (capture) begin
            o_frame    <= frame_cnt_q;  // Number of the frame that just ended
            o_pc       <= i_cpu_pc;
            o_instr    <= i_cpu_instr_count;
            o_iot      <= i_cpu_iot_count;
            o_pv_count <= pv_cnt_q;
            o_running  <= i_cpu_running;
        end
    end

endmodule

// ==== design/msg_formatter.sv ====
// Debug line character lookup, returns the ASCII code at a line index from the held snapshot
module msg_formatter (
    input  dbg_msg_pkg::msg_idx_t         i_char_idx,
    input  logic [dbg_msg_pkg::CNT_W-1:0] i_frame,
    input  logic [dbg_msg_pkg::PC_W-1:0]  i_pc,
    input  logic [dbg_msg_pkg::CNT_W-1:0] i_instr,
    input  logic [dbg_msg_pkg::CNT_W-1:0] i_iot,
    input  logic [dbg_msg_pkg::CNT_W-1:0] i_pv_count,
    input  logic                          i_running,
    output uart_pkg::uart_byte_t          o_char
);

    import uart_pkg::*;
    import dbg_msg_pkg::*;

    localparam logic [CNT_W-1:0] PV_MOD = CNT_W'(10_000);  // Four decimal digits

    // Hex digit of a counter, offset 0 is the top nibble
    function automatic uart_byte_t hex_char(input logic [CNT_W-1:0] value, input msg_idx_t ofs);
        logic [3:0] nib;
        nib = value[CNT_W - 4 - 4 * ofs +: 4];
        if (nib < 4'd10) begin
            return ASCII_0 + {4'd0, nib};
        end
        return ASCII_A + {4'd0, nib} - 8'd10;  // A to F
    endfunction

    function automatic uart_byte_t dec_char(input logic [3:0] digit);
        return ASCII_0 + {4'd0, digit};
    endfunction

    logic [13:0]      pv_mod;     // Pulse count modulo 10000
    logic [3:0][3:0]  dec_digit;  // Index 3 is thousands

    // ========================================
    // Decimal split of the pulse count
    // ========================================
    always_comb begin
        pv_mod       = 14'(i_pv_count % PV_MOD);
        dec_digit[3] = 4'(pv_mod / 14'd1000);
        dec_digit[2] = 4'((pv_mod / 14'd100) % 14'd10);
        dec_digit[1] = 4'((pv_mod / 14'd10) % 14'd10);
        dec_digit[0] = 4'(pv_mod % 14'd10);
    end

    // ========================================
    // Character select
    // ========================================
    always_comb begin
        case (i_char_idx) inside
            POS_FRAME - 6'd2: o_char = "F";
            POS_PC - 6'd3:    o_char = "P";
            POS_PC - 6'd2:    o_char = "C";
            POS_INSTR - 6'd2: o_char = "I";
            POS_IOT - 6'd2:   o_char = "D";
            POS_PV - 6'd2:    o_char = "V";
            POS_FRAME - 6'd1, POS_PC - 6'd1, POS_INSTR - 6'd1,
            POS_IOT - 6'd1, POS_PV - 6'd1: begin
                o_char = ASCII_COLON;
            end
            [POS_FRAME : POS_FRAME + 6'd3]: o_char = hex_char(i_frame, i_char_idx - POS_FRAME);
            // Three digit PC, skip the empty top nibble
            [POS_PC : POS_PC + 6'd2]: begin
                o_char = hex_char(CNT_W'(i_pc), i_char_idx - POS_PC + 6'd1);
            end
            [POS_INSTR : POS_INSTR + 6'd3]: o_char = hex_char(i_instr, i_char_idx - POS_INSTR);
            [POS_IOT : POS_IOT + 6'd3]:     o_char = hex_char(i_iot, i_char_idx - POS_IOT);
            [POS_PV : POS_PV + 6'd3]: begin
                o_char = dec_char(dec_digit[2'(POS_PV + 6'd3 - i_char_idx)]);
            end
            POS_RUN:          o_char = i_running ? ASCII_R : ASCII_DOT;
            POS_RUN + 6'd1:   o_char = ASCII_CR;
            POS_RUN + 6'd2:   o_char = ASCII_LF;
            default:          o_char = ASCII_SPACE;  // Field separators
        endcase
    end

endmodule

// ==== design/msg_sequencer.sv ====
// Debug line sequencer, walks the line characters and feeds them to the UART on send/busy
module msg_sequencer (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_enable,      // Reporting switched on
    input  logic                  i_snap_valid,  // New snapshot ready
    input  uart_pkg::uart_byte_t  i_char,        // Formatter output for o_char_idx
    input  logic                  i_tx_busy,
    output dbg_msg_pkg::msg_idx_t o_char_idx,
    output uart_pkg::uart_byte_t  o_tx_data,
    output logic                  o_tx_send,
    output logic                  o_msg_active
);

    import dbg_msg_pkg::*;

    localparam msg_idx_t LAST_IDX = 6'(MSG_LEN - 1);  // LF

    msg_state_e state_q;
    logic       start_msg;  // Snapshot accepted
    logic       send_now;   // Character handed over this cycle

    assign start_msg = (state_q == MSG_IDLE) && i_snap_valid && i_enable;
    // Busy is always low when a snapshot arrives, so the first character goes at once
    assign send_now  = start_msg || ((state_q == MSG_SEND) && !i_tx_busy);

    // Covers the LF still on the line after the FSM has gone idle
    assign o_msg_active = (state_q != MSG_IDLE) || i_tx_busy;

    // ========================================
    // Message FSM
    // ========================================
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q    <= MSG_IDLE;
            o_char_idx <= '0;
            o_tx_send  <= 1'b0;
        end else begin
            o_tx_send <= send_now;  // Single cycle strobe
            case (state_q)
                MSG_IDLE: begin
                    if (start_msg) begin
                        state_q <= MSG_WAIT;
                    end
                end
                MSG_SEND: begin
                    if (!i_tx_busy) begin
                        state_q <= MSG_WAIT;
                    end
                end
                MSG_WAIT: begin
                    // Busy high means the character was taken
                    if (i_tx_busy) begin
                        if (o_char_idx == LAST_IDX) begin
                            o_char_idx <= '0;  // Ready for next line
                            state_q    <= MSG_IDLE;
                        end else begin
                            o_char_idx <= o_char_idx + 6'd1;
                            state_q    <= MSG_SEND;
                        end
                    end
                end
                default: state_q <= MSG_IDLE;
            endcase
        end
    end

    // Character held for the transmitter
    always_ff @(posedge i_clk) begin
        if (send_now) begin
            o_tx_data <= i_char;
        end
    end

endmodule

// ==== design/serial_debug_top.sv ====
// Serial debug reporter top, sends one status line per frame over the UART when enabled
module serial_debug_top #(
    parameter int CLK_FREQ = 51_000_000,  // System clock in Hz
    parameter int BAUD     = 115_200
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_enable,      // Gates transmission
    input  logic                          i_frame_tick,
    input  logic                          i_pixel_avail,
    input  logic [dbg_msg_pkg::PC_W-1:0]  i_cpu_pc,
    input  logic [dbg_msg_pkg::CNT_W-1:0] i_cpu_instr_count,
    input  logic [dbg_msg_pkg::CNT_W-1:0] i_cpu_iot_count,
    input  logic                          i_cpu_running,
    output logic                          o_uart_tx
);

    import uart_pkg::*;
    import dbg_msg_pkg::*;

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD;  // 442 at the defaults

    // Snapshot
    logic             snap_valid;
    logic [CNT_W-1:0] snap_frame;
    logic [PC_W-1:0]  snap_pc;
    logic [CNT_W-1:0] snap_instr;
    logic [CNT_W-1:0] snap_iot;
    logic [CNT_W-1:0] snap_pv;
    logic             snap_running;
    // Message path
    logic             msg_active;
    msg_idx_t         char_idx;
    uart_byte_t       msg_char;
    uart_byte_t       tx_data;
    logic             tx_send;
    logic             tx_busy;

    frame_stats frame_stats_i (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_frame_tick      (i_frame_tick),
        .i_pixel_avail     (i_pixel_avail),
        .i_cpu_pc          (i_cpu_pc),
        .i_cpu_instr_count (i_cpu_instr_count),
        .i_cpu_iot_count   (i_cpu_iot_count),
        .i_cpu_running     (i_cpu_running),
        .i_msg_active      (msg_active),
        .o_snap_valid      (snap_valid),
        .o_frame           (snap_frame),
        .o_pc              (snap_pc),
        .o_instr           (snap_instr),
        .o_iot             (snap_iot),
        .o_pv_count        (snap_pv),
        .o_running         (snap_running)
    );

    msg_formatter msg_formatter_i (
        .i_char_idx (char_idx),
        .i_frame    (snap_frame),
        .i_pc       (snap_pc),
        .i_instr    (snap_instr),
        .i_iot      (snap_iot),
        .i_pv_count (snap_pv),
        .i_running  (snap_running),
        .o_char     (msg_char)
    );

    msg_sequencer msg_sequencer_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_enable     (i_enable),
        .i_snap_valid (snap_valid),
        .i_char       (msg_char),
        .i_tx_busy    (tx_busy),
        .o_char_idx   (char_idx),
        .o_tx_data    (tx_data),
        .o_tx_send    (tx_send),
        .o_msg_active (msg_active)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_tx_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (tx_data),
        .i_send  (tx_send),
        .o_tx    (o_uart_tx),
        .o_busy  (tx_busy)
    );

endmodule

// ==== testbench/tb_uart_rx_model.sv ====
// Serial receiver model that decodes 8N1 characters for the testbench and flags bad framing or timing
module tb_uart_rx_model #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_rx,        // Serial line under test
    output logic       o_start,     // Start edge seen
    output logic       o_valid,     // One cycle when o_byte is complete
    output logic [7:0] o_byte,
    output logic       o_frame_err  // Sticky until reset
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MID = CLKS_PER_BIT / 2;  // Sample point inside a bit

    logic       busy_q;
    int         cyc_q;    // Clock within the current bit
    int         bit_q;    // 0 start, 1 to 8 data, 9 stop
    logic       level_q;  // First sample of the bit
    logic [7:0] shift_q;  // Data bits with the LSB arriving first

    always_ff @(posedge i_clk) begin
        o_start <= 1'b0;
        o_valid <= 1'b0;
        if (!i_rst_n) begin
            busy_q      <= 1'b0;
            cyc_q       <= 0;
            bit_q       <= 0;
            o_frame_err <= 1'b0;
        end else if (!busy_q) begin
            if (i_rx !== 1'b1) begin  // Anything but a high line ends idle
                busy_q  <= 1'b1;
                o_start <= 1'b1;
                cyc_q   <= 1;
                bit_q   <= 0;
                level_q <= 1'b0;
            end
        end else begin
            // Every sample of a bit must match its first one
            if (cyc_q == 0) begin
                level_q <= i_rx;
            end else if (i_rx !== level_q) begin
                o_frame_err <= 1'b1;
            end
            if (cyc_q == MID) begin
                if (bit_q == 0 && i_rx !== 1'b0) begin
                    o_frame_err <= 1'b1;  // Start bit came back high
                end else if (bit_q == 9 && i_rx !== 1'b1) begin
                    o_frame_err <= 1'b1;  // Stop bit low
                end else if (bit_q >= 1 && bit_q <= 8) begin
                    shift_q <= {i_rx, shift_q[7:1]};
                end
            end
            if (cyc_q == CLKS_PER_BIT - 1) begin
                cyc_q <= 0;
                if (bit_q == 9) begin
                    busy_q  <= 1'b0;  // Back to hunting for a start edge
                    o_valid <= 1'b1;
                    o_byte  <= shift_q;
                end else begin
                    bit_q <= bit_q + 1;
                end
            end else begin
                cyc_q <= cyc_q + 1;
            end
        end
    end

endmodule

// ==== testbench/tb_serial_debug.sv ====
// Testbench top that drives frames and CPU counters into the serial debug reporter and checks each line
module tb_serial_debug;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int CLK_FREQ     = 800_000;
    localparam int BAUD         = 100_000;
    localparam int CLKS_PER_BIT = 8;  // Bit period at these rates
    localparam int SEED         = 81995;
    localparam int LINE_CYCLES  = 38 * (10 * CLKS_PER_BIT + 3);  // Worst case character gaps
    // Frame lengths of the sequence below plus two cycles per tick
    localparam int RUN_CYCLES   = 400 + 3300 + 10600 + 1500 + 2000 + 3300 + 3300 + 800 + 8 * 2;
    localparam int TIMEOUT      = 16 + RUN_CYCLES + LINE_CYCLES + 1000;

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic        frame_tick;
    logic        pixel_avail;
    logic [11:0] cpu_pc;
    logic [15:0] cpu_instr;
    logic [15:0] cpu_iot;
    logic        cpu_running;
    logic        uart_tx;
    logic        rx_start;
    logic        rx_valid;
    logic        rx_frame_err;
    logic [7:0]  rx_byte;

    logic [7:0]  exp_q[$];       // Characters still due on the line
    int          frame_num;      // Ticks given since reset
    int          pv_count;       // Pixel pulses since the last tick
    int          cycle_cnt = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    serial_debug_top #(
        .CLK_FREQ (CLK_FREQ),
        .BAUD     (BAUD)
    ) dut_i (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_enable          (enable),
        .i_frame_tick      (frame_tick),
        .i_pixel_avail     (pixel_avail),
        .i_cpu_pc          (cpu_pc),
        .i_cpu_instr_count (cpu_instr),
        .i_cpu_iot_count   (cpu_iot),
        .i_cpu_running     (cpu_running),
        .o_uart_tx         (uart_tx)
    );

    tb_uart_rx_model #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) rx_model_i (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_rx        (uart_tx),
        .o_start     (rx_start),
        .o_valid     (rx_valid),
        .o_byte      (rx_byte),
        .o_frame_err (rx_frame_err)
    );

    // ========================================
    // Failure reporting
    // ========================================
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic mismatch_stop(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
        $display("Checks failed");
        $fatal(1);
    endtask

    // ========================================
    // Expected line builder
    // ========================================
    function automatic logic [7:0] hex_ascii(input int nib);
        return (nib < 10) ? 8'(8'h30 + nib) : 8'(8'h41 + nib - 10);  // 0-9 then A-F
    endfunction

    function automatic void push_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            exp_q.push_back(s[i]);
        end
    endfunction

    function automatic void push_hex(input int value, input int digits);
        for (int d = digits - 1; d >= 0; d--) begin
            exp_q.push_back(hex_ascii((value >> (4 * d)) & 15));  // Top nibble first
        end
    endfunction

    function automatic void queue_line(input int frame, input int pc, input int instr,
                                       input int iot, input int pv, input logic running);
        int dec;
        dec = pv % 10000;  // Four digits only
        push_text("F:");
        push_hex(frame, 4);
        push_text(" PC:");
        push_hex(pc, 3);
        push_text(" I:");
        push_hex(instr, 4);
        push_text(" D:");
        push_hex(iot, 4);
        push_text(" V:");
        exp_q.push_back(8'(8'h30 + dec / 1000));
        exp_q.push_back(8'(8'h30 + (dec / 100) % 10));
        exp_q.push_back(8'(8'h30 + (dec / 10) % 10));
        exp_q.push_back(8'(8'h30 + dec % 10));
        push_text(running ? " R" : " .");
        exp_q.push_back(8'h0D);  // CR
        exp_q.push_back(8'h0A);  // LF
    endfunction

    // ========================================
    // Stimulus tasks
    // ========================================
    // New CPU values on the first cycle and exactly `pulses` pixel pulses spread at random
    task automatic run_frame(input int cycles, input int pulses, input logic running);
        int left;
        left = pulses;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            if (c == 0) begin
                cpu_pc      <= 12'($urandom);
                cpu_instr   <= 16'($urandom);
                cpu_iot     <= 16'($urandom);
                cpu_running <= running;
            end
            if (left > 0 && (left >= cycles - c || $urandom_range(0, 1) == 1)) begin
                pixel_avail <= 1'b1;
                left--;
                pv_count++;
            end else begin
                pixel_avail <= 1'b0;
            end
        end
    endtask

    task automatic give_tick(input logic expect_line);
        @(posedge clk);
        frame_tick  <= 1'b1;
        pixel_avail <= 1'b0;  // No pulse on the tick cycle
        if (expect_line) begin
            queue_line(frame_num, cpu_pc, cpu_instr, cpu_iot, pv_count, cpu_running);
        end
        frame_num++;
        pv_count = 0;
        @(posedge clk);
        frame_tick <= 1'b0;
    endtask

    // ========================================
    // Line checks
    // ========================================
    always @(posedge clk) begin
        if (rst_n) begin
            assert (!rx_frame_err)
                else abort_run({"Bad framing on o_uart_tx, ",
                                "unsteady bit or wrong start or stop level"});
            if (rx_start) begin
                assert (exp_q.size() > 0)
                    else abort_run("o_uart_tx left the idle level while no line was due");
            end
            if (rx_valid) begin
                assert (exp_q.size() > 0)
                    else abort_run("Character received on o_uart_tx while no line was due");
                assert (rx_byte == exp_q[0])
                    else mismatch_stop($sformatf("o_uart_tx char %0d", 38 - exp_q.size()),
                                       rx_byte, exp_q[0]);
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            abort_run($sformatf("Timeout after %0d cycles, lines still pending", cycle_cnt));
        end
    end

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        void'($urandom(SEED));
        clk         = 1'b0;
        rst_n       = 1'b0;
        enable      = 1'b1;
        frame_tick  = 1'b0;
        pixel_avail = 1'b0;
        cpu_pc      = '0;
        cpu_instr   = '0;
        cpu_iot     = '0;
        cpu_running = 1'b0;
        frame_num   = 0;
        pv_count    = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        run_frame(400, 0, 1'b1);  // Line must stay idle
        give_tick(1'b1);          // F 0000, V 0000, running
        run_frame(3300, $urandom_range(1, 3000), 1'b0);
        give_tick(1'b1);          // Halted
        run_frame(10600, 10000 + $urandom_range(0, 500), 1'($urandom_range(0, 1)));
        give_tick(1'b1);          // V wraps past 9999
        run_frame(1500, $urandom_range(0, 1400), 1'($urandom_range(0, 1)));
        give_tick(1'b0);          // Lands inside the line and is only counted
        run_frame(2000, $urandom_range(0, 1900), 1'($urandom_range(0, 1)));
        give_tick(1'b1);          // F skips by two
        run_frame(3300, $urandom_range(0, 3000), 1'($urandom_range(0, 1)));
        enable <= 1'b0;
        give_tick(1'b0);
        // Full line time with no output
        run_frame(3300, $urandom_range(0, 3000), 1'($urandom_range(0, 1)));
        give_tick(1'b0);
        run_frame(400, $urandom_range(0, 300), 1'($urandom_range(0, 1)));
        enable <= 1'b1;
        run_frame(400, $urandom_range(0, 300), 1'($urandom_range(0, 1)));
        give_tick(1'b1);          // Frame count includes the skipped ticks
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (200) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== build.f ====
design/uart_pkg.sv
design/dbg_msg_pkg.sv
design/baud_timer.sv
design/uart_tx.sv
design/frame_stats.sv
design/msg_formatter.sv
design/msg_sequencer.sv
design/serial_debug_top.sv
testbench/tb_uart_rx_model.sv
testbench/tb_serial_debug.sv

// ==== Bender.yml ====
package:
  name: serial_debug_reporter

sources:
  # Packages first, then the modules that import them
  - design/uart_pkg.sv
  - design/dbg_msg_pkg.sv
  - design/baud_timer.sv
  - design/uart_tx.sv
  - design/frame_stats.sv
  - design/msg_formatter.sv
  - design/msg_sequencer.sv
  - design/serial_debug_top.sv
  - target: test
    files:
      - testbench/tb_uart_rx_model.sv
      - testbench/tb_serial_debug.sv
